// File: all.f
design/core_region_pkg.sv
design/irq_id_encoder.sv
design/lsu_demux.sv
design/ram_arbiter.sv
design/sp_ram.sv
design/core_region.sv
tests/tb_core_region.sv

// File: design/core_region.sv
`timescale 1ns/100ps
`default_nettype none

module core_region #(
  parameter int DATA_RAM_SIZE = 32768
) (
  input  logic                     clk,
  input  logic                     rst_n,

  // interrupts
  input  core_region_pkg::irq_vec_t irq_i,
  output logic                      irq_o,
  output core_region_pkg::irq_id_t  irq_id_o,

  // load/store unit
  input  logic                      lsu_req_i,
  output logic                      lsu_gnt_o,
  output logic                      lsu_rvalid_o,
  input  core_region_pkg::word_t    lsu_addr_i,
  input  logic                      lsu_we_i,
  input  core_region_pkg::be_t      lsu_be_i,
  input  core_region_pkg::word_t    lsu_wdata_i,
  output core_region_pkg::word_t    lsu_rdata_o,

  // external bus
  output logic                      ext_req_o,
  input  logic                      ext_gnt_i,
  input  logic                      ext_rvalid_i,
  output core_region_pkg::word_t    ext_addr_o,
  output logic                      ext_we_o,
  output core_region_pkg::be_t      ext_be_o,
  output core_region_pkg::word_t    ext_wdata_o,
  input  core_region_pkg::word_t    ext_rdata_i,

  // loader
  input  logic                      load_req_i,
  input  logic                      load_we_i,
  input  core_region_pkg::word_t    load_addr_i,
  input  core_region_pkg::be_t      load_be_i,
  input  core_region_pkg::word_t    load_wdata_i,
  output core_region_pkg::word_t    load_rdata_o
);

  import core_region_pkg::*;

  page_t lsu_page;

  logic  data_req;
  logic  data_gnt;
  logic  data_rvalid;

  logic  ram_en;
  logic  ram_we;
  word_t ram_addr;
  be_t   ram_be;
  word_t ram_wdata;
  word_t ram_rdata;

  assign lsu_page = lsu_addr_i[31:20];

  // request fields go to both sides, only the strobe is steered
  assign ext_addr_o  = lsu_addr_i;
  assign ext_we_o    = lsu_we_i;
  assign ext_be_o    = lsu_be_i;
  assign ext_wdata_o = lsu_wdata_i;

  // loader reads share the RAM output
  assign load_rdata_o = ram_rdata;

  irq_id_encoder irq_enc0 (
    .irq_i    (irq_i),
    .irq_o    (irq_o),
    .irq_id_o (irq_id_o)
  );

  lsu_demux lsu_demux0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_page_i   (lsu_page),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ram_req_o    (data_req),
    .ram_gnt_i    (data_gnt),
    .ram_rvalid_i (data_rvalid),
    .ram_rdata_i  (ram_rdata),
    .ext_req_o    (ext_req_o),
    .ext_gnt_i    (ext_gnt_i),
    .ext_rvalid_i (ext_rvalid_i),
    .ext_rdata_i  (ext_rdata_i)
  );

  ram_arbiter ram_arb0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .load_req_i    (load_req_i),
    .load_we_i     (load_we_i),
    .load_addr_i   (load_addr_i),
    .load_be_i     (load_be_i),
    .load_wdata_i  (load_wdata_i),
    .core_req_i    (data_req),
    .core_we_i     (lsu_we_i),
    .core_addr_i   (lsu_addr_i),
    .core_be_i     (lsu_be_i),
    .core_wdata_i  (lsu_wdata_i),
    .core_gnt_o    (data_gnt),
    .core_rvalid_o (data_rvalid),
    .ram_en_o      (ram_en),
    .ram_we_o      (ram_we),
    .ram_addr_o    (ram_addr),
    .ram_be_o      (ram_be),
    .ram_wdata_o   (ram_wdata)
  );

  sp_ram #(
    .DATA_RAM_SIZE (DATA_RAM_SIZE)
  ) data_mem0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .en_i    (ram_en),
    .we_i    (ram_we),
    .addr_i  (ram_addr),
    .be_i    (ram_be),
    .wdata_i (ram_wdata),
    .rdata_o (ram_rdata)
  );

endmodule

`default_nettype wire

// File: design/core_region_pkg.sv
`default_nettype none

package core_region_pkg;

  // address or data word on every port
  typedef logic [31:0] word_t;

  // one enable bit per byte of a word
  typedef logic [3:0] be_t;

  // interrupt lines and the index of one line
  typedef logic [31:0] irq_vec_t;
  typedef logic [4:0]  irq_id_t;

  // address bits 31:20
  typedef logic [11:0] page_t;

  // window of the local data RAM
  localparam page_t LOCAL_DATA_PAGE = 12'h001;

  // source of the pending load/store response
  typedef enum logic [0:0] {
    RESP_EXT,
    RESP_RAM
  } lsu_resp_e;

endpackage

`default_nettype wire

// File: design/irq_id_encoder.sv
`timescale 1ns/100ps
`default_nettype none

module irq_id_encoder (
  input  core_region_pkg::irq_vec_t irq_i,
  output logic                      irq_o,
  output core_region_pkg::irq_id_t  irq_id_o
);

  import core_region_pkg::*;

  // any pending line
  assign irq_o = |irq_i;

  // later matches overwrite earlier ones, so the highest set line wins
  always_comb begin
    irq_id_o = '0;
    for (int i = 0; i < $bits(irq_vec_t); i++) begin
      if (irq_i[i]) begin
        irq_id_o = irq_id_t'(i);
      end
    end
  end

endmodule

`default_nettype wire

// File: design/lsu_demux.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_demux (
  input  logic                   clk,
  input  logic                   rst_n,

  input  logic                   lsu_req_i,
  input  core_region_pkg::page_t lsu_page_i,
  output logic                   lsu_gnt_o,
  output logic                   lsu_rvalid_o,
  output core_region_pkg::word_t lsu_rdata_o,

  output logic                   ram_req_o,
  input  logic                   ram_gnt_i,
  input  logic                   ram_rvalid_i,
  input  core_region_pkg::word_t ram_rdata_i,

  output logic                   ext_req_o,
  input  logic                   ext_gnt_i,
  input  logic                   ext_rvalid_i,
  input  core_region_pkg::word_t ext_rdata_i
);

  import core_region_pkg::*;

  logic      is_local;
  lsu_resp_e resp_q;
  lsu_resp_e resp_d;

  assign is_local  = (lsu_page_i == LOCAL_DATA_PAGE);
  assign ram_req_o = lsu_req_i & is_local;
  assign ext_req_o = lsu_req_i & ~is_local;

  // grant comes from whichever side got the request
  always_comb begin
    lsu_gnt_o = 1'b0;
    resp_d    = resp_q;
    if (ext_req_o) begin
      lsu_gnt_o = ext_gnt_i;
      resp_d    = RESP_EXT;
    end else if (ram_req_o) begin
      lsu_gnt_o = ram_gnt_i;
      resp_d    = RESP_RAM;
    end
  end

  // remember the side of the last accepted request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_q <= RESP_RAM;
    end else if (lsu_gnt_o) begin
      resp_q <= resp_d;
    end
  end

  // only one side answers at a time
  assign lsu_rvalid_o = ram_rvalid_i | ext_rvalid_i;
  assign lsu_rdata_o  = (resp_q == RESP_EXT) ? ext_rdata_i : ram_rdata_i;

endmodule

`default_nettype wire

// File: design/ram_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module ram_arbiter (
  input  logic                   clk,
  input  logic                   rst_n,

  // loader port, never stalled
  input  logic                   load_req_i,
  input  logic                   load_we_i,
  input  core_region_pkg::word_t load_addr_i,
  input  core_region_pkg::be_t   load_be_i,
  input  core_region_pkg::word_t load_wdata_i,

  // load/store port
  input  logic                   core_req_i,
  input  logic                   core_we_i,
  input  core_region_pkg::word_t core_addr_i,
  input  core_region_pkg::be_t   core_be_i,
  input  core_region_pkg::word_t core_wdata_i,
  output logic                   core_gnt_o,
  output logic                   core_rvalid_o,

  // shared RAM port
  output logic                   ram_en_o,
  output logic                   ram_we_o,
  output core_region_pkg::word_t ram_addr_o,
  output core_region_pkg::be_t   ram_be_o,
  output core_region_pkg::word_t ram_wdata_o
);

  // core only gets the RAM when the loader is idle
  assign core_gnt_o = core_req_i & ~load_req_i;
  assign ram_en_o   = load_req_i | core_req_i;

  always_comb begin
    if (load_req_i) begin
      ram_we_o    = load_we_i;
      ram_addr_o  = load_addr_i;
      ram_be_o    = load_be_i;
      ram_wdata_o = load_wdata_i;
    end else begin
      ram_we_o    = core_we_i;
      ram_addr_o  = core_addr_i;
      ram_be_o    = core_be_i;
      ram_wdata_o = core_wdata_i;
    end
  end

  // read data shows up one cycle after the access, reads and writes alike
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      core_rvalid_o <= 1'b0;
    end else begin
      core_rvalid_o <= core_gnt_o;
    end
  end

endmodule

`default_nettype wire

// File: design/sp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module sp_ram #(
  parameter int DATA_RAM_SIZE = 32768
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   en_i,
  input  logic                   we_i,
  input  core_region_pkg::word_t addr_i,
  input  core_region_pkg::be_t   be_i,
  input  core_region_pkg::word_t wdata_i,
  output core_region_pkg::word_t rdata_o
);

  import core_region_pkg::*;

  localparam int NUM_WORDS = DATA_RAM_SIZE / 4;
  localparam int ADDR_W    = $clog2(NUM_WORDS);

  word_t             mem [NUM_WORDS];
  logic [ADDR_W-1:0] word_idx;

  // byte address to word index, upper bits ignored
  assign word_idx = addr_i[ADDR_W+1:2];

  always_ff @(posedge clk) begin
    if (en_i && we_i) begin
      for (int b = 0; b < $bits(be_t); b++) begin
        if (be_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read before write, holds when idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_o <= '0;
    end else if (en_i) begin
      rdata_o <= mem[word_idx];
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, pass is decided from the log
rm -rf obj_dir sim.log &&
verilator --binary --timing -f all.f --top-module tb_core_region &&
./obj_dir/Vtb_core_region > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && exit 0 || exit 1

// File: tests/tb_core_region.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core_region;

  import core_region_pkg::*;

  // the tests take about 100 cycles
  localparam int    MAX_CYCLES = 2000;
  localparam word_t BASE       = 32'h0010_0000;

  logic     clk = 1'b0;
  logic     rst_n;
  irq_vec_t irq_i;
  logic     irq_o;
  irq_id_t  irq_id_o;
  logic     lsu_req_i, lsu_gnt_o, lsu_rvalid_o, lsu_we_i;
  word_t    lsu_addr_i, lsu_wdata_i, lsu_rdata_o;
  be_t      lsu_be_i;
  logic     ext_req_o, ext_gnt_i, ext_rvalid_i, ext_we_o;
  word_t    ext_addr_o, ext_wdata_o, ext_rdata_i;
  be_t      ext_be_o;
  logic     load_req_i, load_we_i;
  word_t    load_addr_i, load_wdata_i, load_rdata_o;
  be_t      load_be_i;

  word_t    rng_state;
  word_t    ref_mem [8];
  int       cycle_cnt = 0;

  core_region dut0 (.*);

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    assert (cycle_cnt < MAX_CYCLES) else begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $fatal(1);
    end
  end

  function automatic word_t xorshift32(input word_t x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // reference merge of a partial write
  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic int highest_set(input irq_vec_t v);
    for (int b = 31; b >= 0; b--) begin
      if (v[b]) return b;
    end
    return 0;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    assert (act === exp) else begin
      $display("error %s: expected %h, actual %h", name, exp, act);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic drive_lsu(input logic req, input logic we, input word_t addr, input be_t be,
                           input word_t wdata);
    lsu_req_i   = req;
    lsu_we_i    = we;
    lsu_addr_i  = addr;
    lsu_be_i    = be;
    lsu_wdata_i = wdata;
  endtask

  // one loader cycle with read data valid on return
  task automatic loader_access(input logic we, input word_t addr, input word_t wdata);
    load_req_i   = 1'b1;
    load_we_i    = we;
    load_addr_i  = addr;
    load_be_i    = 4'hf;
    load_wdata_i = wdata;
    next_cycle();
    load_req_i = 1'b0;
    load_we_i  = 1'b0;
  endtask

  // local access is granted at once and answered one cycle later
  task automatic local_access(input string name, input logic we, input word_t addr,
                              input be_t be, input word_t wdata, input word_t exp_rdata);
    drive_lsu(1'b1, we, addr, be, wdata);
    #1;
    check_value({name, " gnt"}, 32'd1, word_t'(lsu_gnt_o));
    check_value({name, " ext_req"}, 32'd0, word_t'(ext_req_o));
    next_cycle();
    drive_lsu(1'b0, 1'b0, addr, 4'h0, 32'h0);
    check_value({name, " rvalid"}, 32'd1, word_t'(lsu_rvalid_o));
    if (!we) check_value({name, " rdata"}, exp_rdata, lsu_rdata_o);
  endtask

  // bus slave grants one cycle after the request and answers two cycles later
  task automatic ext_access(input string name, input logic we, input word_t addr,
                            input be_t be, input word_t wdata);
    word_t resp;
    resp = next_rand();
    drive_lsu(1'b1, we, addr, be, wdata);
    #1;
    check_value({name, " ext_req"}, 32'd1, word_t'(ext_req_o));
    check_value({name, " ext_addr"}, addr, ext_addr_o);
    check_value({name, " ext_we"}, word_t'(we), word_t'(ext_we_o));
    check_value({name, " ext_be"}, word_t'(be), word_t'(ext_be_o));
    check_value({name, " ext_wdata"}, wdata, ext_wdata_o);
    check_value({name, " gnt before ext_gnt"}, 32'd0, word_t'(lsu_gnt_o));
    next_cycle();
    ext_gnt_i = 1'b1;
    #1;
    check_value({name, " gnt"}, 32'd1, word_t'(lsu_gnt_o));
    next_cycle();
    drive_lsu(1'b0, 1'b0, 32'h0, 4'h0, 32'h0);
    ext_gnt_i = 1'b0;
    check_value({name, " early rvalid"}, 32'd0, word_t'(lsu_rvalid_o));
    next_cycle();
    ext_rvalid_i = 1'b1;
    ext_rdata_i  = resp;
    #1;
    check_value({name, " rvalid"}, 32'd1, word_t'(lsu_rvalid_o));
    if (!we) check_value({name, " rdata"}, resp, lsu_rdata_o);
    next_cycle();
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = 32'h0;
  endtask

  task automatic reset_idle_test();
    next_cycle();
    check_value("reset_idle gnt", 32'd0, word_t'(lsu_gnt_o));
    check_value("reset_idle rvalid", 32'd0, word_t'(lsu_rvalid_o));
    check_value("reset_idle ext_req", 32'd0, word_t'(ext_req_o));
  endtask

  task automatic loader_readback_test();
    for (int i = 0; i < 8; i++) begin
      ref_mem[i] = next_rand();
      loader_access(1'b1, BASE + 4 * i, ref_mem[i]);
    end
    loader_access(1'b0, BASE + 4 * 3, 32'h0);
    check_value("loader_readback load_rdata", ref_mem[3], load_rdata_o);
    for (int i = 0; i < 8; i++) begin
      local_access("loader_readback", 1'b0, BASE + 4 * i, 4'hf, 32'h0, ref_mem[i]);
    end
  endtask

  task automatic byte_enable_test();
    word_t d;
    d = next_rand();
    local_access("byte_enable wr", 1'b1, BASE + 8, 4'b0101, d, 32'h0);
    ref_mem[2] = merge_bytes(ref_mem[2], d, 4'b0101);
    local_access("byte_enable rd", 1'b0, BASE + 8, 4'hf, 32'h0, ref_mem[2]);
    d = next_rand();
    local_access("byte_enable wr", 1'b1, BASE + 20, 4'b1000, d, 32'h0);
    ref_mem[5] = merge_bytes(ref_mem[5], d, 4'b1000);
    local_access("byte_enable rd", 1'b0, BASE + 20, 4'hf, 32'h0, ref_mem[5]);
  endtask

  // loader and load/store collide on the same word
  task automatic arbitration_test();
    word_t d;
    d = next_rand();
    load_req_i   = 1'b1;
    load_we_i    = 1'b1;
    load_addr_i  = BASE + 24;
    load_be_i    = 4'hf;
    load_wdata_i = d;
    drive_lsu(1'b1, 1'b0, BASE + 24, 4'hf, 32'h0);
    #1;
    check_value("arbitration stalled gnt", 32'd0, word_t'(lsu_gnt_o));
    next_cycle();
    load_req_i = 1'b0;
    load_we_i  = 1'b0;
    ref_mem[6] = d;
    check_value("arbitration stalled rvalid", 32'd0, word_t'(lsu_rvalid_o));
    #1;
    check_value("arbitration gnt", 32'd1, word_t'(lsu_gnt_o));
    next_cycle();
    drive_lsu(1'b0, 1'b0, 32'h0, 4'h0, 32'h0);
    check_value("arbitration rvalid", 32'd1, word_t'(lsu_rvalid_o));
    check_value("arbitration rdata", ref_mem[6], lsu_rdata_o);
  endtask

  task automatic external_test();
    ext_access("external wr", 1'b1, 32'h2000_0040, 4'b0011, next_rand());
    ext_access("external rd", 1'b0, 32'h2000_0044, 4'hf, 32'h0);
    // response source has to switch back to the RAM
    local_access("external local rd", 1'b0, BASE + 4, 4'hf, 32'h0, ref_mem[1]);
  endtask

  task automatic apply_irq(input irq_vec_t v);
    next_cycle();
    irq_i = v;
    #1;
    check_value("irq flag", word_t'(v != '0), word_t'(irq_o));
    check_value("irq id", word_t'(highest_set(v)), word_t'(irq_id_o));
  endtask

  task automatic irq_test();
    apply_irq(32'h0);
    for (int i = 0; i < 32; i++) begin
      apply_irq(32'h1 << i);
    end
    for (int i = 0; i < 20; i++) begin
      apply_irq(next_rand());
    end
  endtask

  initial begin
    rng_state = 32'd7362;
    rst_n     = 1'b0;
    irq_i     = '0;
    drive_lsu(1'b0, 1'b0, 32'h0, 4'h0, 32'h0);
    ext_gnt_i    = 1'b0;
    ext_rvalid_i = 1'b0;
    ext_rdata_i  = 32'h0;
    load_req_i   = 1'b0;
    load_we_i    = 1'b0;
    load_addr_i  = 32'h0;
    load_be_i    = 4'h0;
    load_wdata_i = 32'h0;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    reset_idle_test();
    loader_readback_test();
    byte_enable_test();
    arbitration_test();
    external_test();
    irq_test();
    $display("All checks passed");
    $finish;
  end

endmodule

`default_nettype wire
